// ==== design/rv_byte_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_byte_core #(
  parameter logic [rv_byte_pkg::XLEN-1:0] RESET_PC = '0
) (
  input  wire logic                           clk,
  input  wire logic                           rst,
  input  wire logic                           rdy_i,
  input  wire logic [7:0]                     mem_data_i,
  output logic      [rv_byte_pkg::XLEN-1:0]   mem_addr_o,
  output logic                                wb_valid_o,
  output logic      [rv_byte_pkg::REG_AW-1:0] wb_rd_o,
  output logic      [rv_byte_pkg::XLEN-1:0]   wb_data_o
);
  import rv_byte_pkg::*;

  // fetch to decode
  rv_instr_u           instr;
  logic                instr_valid;
  // decode and register file
  logic [REG_AW-1:0]   rs1_addr;
  logic [REG_AW-1:0]   rs2_addr;
  logic [XLEN-1:0]     rs1_data;
  logic [XLEN-1:0]     rs2_data;
  // decode to execute
  logic                op_valid;
  logic [ALU_OP_W-1:0] alu_op;
  logic [XLEN-1:0]     opnd_a;
  logic [XLEN-1:0]     opnd_b;
  logic [REG_AW-1:0]   rd;

  rv_fetch #(.RESET_PC(RESET_PC)) u_fetch (
    .clk(clk), .rst(rst), .rdy_i(rdy_i), .mem_data_i(mem_data_i),
    .mem_addr_o(mem_addr_o), .instr_o(instr), .instr_valid_o(instr_valid)
  );

  rv_decode u_decode (
    .clk(clk), .rst(rst), .rdy_i(rdy_i),
    .instr_i(instr), .instr_valid_i(instr_valid),
    .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
    .rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr),
    .op_valid_o(op_valid), .alu_op_o(alu_op),
    .opnd_a_o(opnd_a), .opnd_b_o(opnd_b), .rd_o(rd)
  );

  // a held wb strobe during a stall rewrites the same value
  rv_regfile u_regfile (
    .clk(clk), .rst(rst),
    .rs1_addr_i(rs1_addr), .rs2_addr_i(rs2_addr),
    .we_i(wb_valid_o), .rd_i(wb_rd_o), .wd_i(wb_data_o),
    .rs1_data_o(rs1_data), .rs2_data_o(rs2_data)
  );

  rv_execute u_execute (
    .clk(clk), .rst(rst), .rdy_i(rdy_i),
    .op_valid_i(op_valid), .alu_op_i(alu_op),
    .opnd_a_i(opnd_a), .opnd_b_i(opnd_b), .rd_i(rd),
    .wb_valid_o(wb_valid_o), .wb_rd_o(wb_rd_o), .wb_data_o(wb_data_o)
  );

endmodule

`default_nettype wire

// ==== design/rv_byte_pkg.sv ====
`default_nettype none

package rv_byte_pkg;

  // data path and address width
  parameter int XLEN = 32;
  // register index width, 32 architectural registers
  parameter int REG_AW = 5;

  // major opcodes, only the two integer ALU groups are decoded
  parameter logic [6:0] OPC_OP     = 7'b0110011;
  parameter logic [6:0] OPC_OP_IMM = 7'b0010011;

  // funct3 codes, identical for the register and immediate forms
  parameter logic [2:0] F3_ADD = 3'b000;
  parameter logic [2:0] F3_XOR = 3'b100;
  parameter logic [2:0] F3_OR  = 3'b110;
  parameter logic [2:0] F3_AND = 3'b111;

  // alu op codes passed from decode to execute
  parameter int ALU_OP_W = 3;
  parameter logic [ALU_OP_W-1:0] ALU_ADD = 3'd0;
  parameter logic [ALU_OP_W-1:0] ALU_SUB = 3'd1;
  parameter logic [ALU_OP_W-1:0] ALU_XOR = 3'd2;
  parameter logic [ALU_OP_W-1:0] ALU_OR  = 3'd3;
  parameter logic [ALU_OP_W-1:0] ALU_AND = 3'd4;

  // one instruction word seen as R-type or as I-type
  typedef union packed {
    // register-register layout
    struct packed {
      logic [6:0]        funct7;
      logic [REG_AW-1:0] rs2;
      logic [REG_AW-1:0] rs1;
      logic [2:0]        funct3;
      logic [REG_AW-1:0] rd;
      logic [6:0]        opcode;
    } r_view;
    // register-immediate layout, imm is sign-extended later
    struct packed {
      logic [11:0]       imm;
      logic [REG_AW-1:0] rs1;
      logic [2:0]        funct3;
      logic [REG_AW-1:0] rd;
      logic [6:0]        opcode;
    } i_view;
  } rv_instr_u;

endpackage

`default_nettype wire

// ==== design/rv_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_decode (
  input  wire logic                             clk,
  input  wire logic                             rst,
  input  wire logic                             rdy_i,
  input  wire rv_byte_pkg::rv_instr_u           instr_i,
  input  wire logic                             instr_valid_i,
  input  wire logic [rv_byte_pkg::XLEN-1:0]     rs1_data_i,
  input  wire logic [rv_byte_pkg::XLEN-1:0]     rs2_data_i,
  output logic      [rv_byte_pkg::REG_AW-1:0]   rs1_addr_o,
  output logic      [rv_byte_pkg::REG_AW-1:0]   rs2_addr_o,
  output logic                                  op_valid_o,
  output logic      [rv_byte_pkg::ALU_OP_W-1:0] alu_op_o,
  output logic      [rv_byte_pkg::XLEN-1:0]     opnd_a_o,
  output logic      [rv_byte_pkg::XLEN-1:0]     opnd_b_o,
  output logic      [rv_byte_pkg::REG_AW-1:0]   rd_o
);
  import rv_byte_pkg::*;

  logic                is_op;
  logic                is_op_imm;
  logic [2:0]          funct3;
  logic                f3_ok;
  logic                f7_ok;
  logic                legal;
  logic [ALU_OP_W-1:0] alu_op_d;
  logic [XLEN-1:0]     imm_ext;

  // opcode sits in the same bits in both views
  assign is_op     = (instr_i.r_view.opcode == OPC_OP);
  assign is_op_imm = (instr_i.i_view.opcode == OPC_OP_IMM);

  // funct3, rs1 and rd share their bits in both views
  assign funct3 = instr_i.r_view.funct3;

  // funct3 to alu op, funct7 bit 5 turns an R-type add into sub
  always_comb begin
    f3_ok    = 1'b1;
    alu_op_d = ALU_ADD;
    case (funct3)
      F3_ADD: alu_op_d = (is_op && instr_i.r_view.funct7[5]) ? ALU_SUB : ALU_ADD;
      F3_XOR: alu_op_d = ALU_XOR;
      F3_OR:  alu_op_d = ALU_OR;
      F3_AND: alu_op_d = ALU_AND;
      default: f3_ok = 1'b0;
    endcase
  end

  // only funct7 of zero, or 0100000 with add, is a known R-type
  assign f7_ok = !is_op
              || (instr_i.r_view.funct7 == 7'b0000000)
              || (funct3 == F3_ADD && instr_i.r_view.funct7 == 7'b0100000);

  assign legal = (is_op || is_op_imm) && f3_ok && f7_ok;

  assign rs1_addr_o = instr_i.r_view.rs1;
  // rs2 only matters for R-type, unused data otherwise
  assign rs2_addr_o = instr_i.r_view.rs2;

  assign imm_ext = {{(XLEN-12){instr_i.i_view.imm[11]}}, instr_i.i_view.imm};

  // unsupported words simply produce no op_valid_o
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      op_valid_o <= 1'b0;
    end else if (rdy_i) begin
      op_valid_o <= instr_valid_i && legal;
    end
  end

  // operands captured the cycle after the word arrives
  always_ff @(posedge clk) begin
    if (rdy_i && instr_valid_i) begin
      alu_op_o <= alu_op_d;
      opnd_a_o <= rs1_data_i;
      opnd_b_o <= is_op ? rs2_data_i : imm_ext;
      rd_o     <= instr_i.r_view.rd;
    end
  end

endmodule

`default_nettype wire

// ==== design/rv_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_execute (
  input  wire logic                             clk,
  input  wire logic                             rst,
  input  wire logic                             rdy_i,
  input  wire logic                             op_valid_i,
  input  wire logic [rv_byte_pkg::ALU_OP_W-1:0] alu_op_i,
  input  wire logic [rv_byte_pkg::XLEN-1:0]     opnd_a_i,
  input  wire logic [rv_byte_pkg::XLEN-1:0]     opnd_b_i,
  input  wire logic [rv_byte_pkg::REG_AW-1:0]   rd_i,
  output logic                                  wb_valid_o,
  output logic      [rv_byte_pkg::REG_AW-1:0]   wb_rd_o,
  output logic      [rv_byte_pkg::XLEN-1:0]     wb_data_o
);
  import rv_byte_pkg::*;

  logic [XLEN-1:0] alu_res;

  // add and sub wrap modulo 2^32
  always_comb begin
    case (alu_op_i)
      ALU_ADD: alu_res = opnd_a_i + opnd_b_i;
      ALU_SUB: alu_res = opnd_a_i - opnd_b_i;
      ALU_XOR: alu_res = opnd_a_i ^ opnd_b_i;
      ALU_OR:  alu_res = opnd_a_i | opnd_b_i;
      ALU_AND: alu_res = opnd_a_i & opnd_b_i;
      default: alu_res = '0;
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wb_valid_o <= 1'b0;
    end else if (rdy_i) begin
      wb_valid_o <= op_valid_i;
    end
  end

  // result and index only move along with a valid op
  always_ff @(posedge clk) begin
    if (rdy_i && op_valid_i) begin
      wb_rd_o   <= rd_i;
      wb_data_o <= alu_res;
    end
  end

endmodule

`default_nettype wire

// ==== design/rv_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_fetch #(
  parameter logic [rv_byte_pkg::XLEN-1:0] RESET_PC = '0
) (
  input  wire logic                         clk,
  input  wire logic                         rst,
  input  wire logic                         rdy_i,
  input  wire logic [7:0]                   mem_data_i,
  output logic      [rv_byte_pkg::XLEN-1:0] mem_addr_o,
  output logic      [rv_byte_pkg::XLEN-1:0] instr_o,
  output logic                              instr_valid_o
);
  import rv_byte_pkg::*;

  // st_addr puts the word address on the bus, st_b0..st_b3 take the bytes
  localparam logic [2:0] ST_ADDR = 3'd0;
  localparam logic [2:0] ST_B0   = 3'd1;
  localparam logic [2:0] ST_B1   = 3'd2;
  localparam logic [2:0] ST_B2   = 3'd3;
  localparam logic [2:0] ST_B3   = 3'd4;

  logic [2:0] state;
  // rdy_i seen in the previous cycle
  logic       rdy_q;
  // byte that arrived in the first cycle of a stall
  logic [7:0] byte_hold;
  logic [7:0] byte_in;

  // memory keeps answering the held address while stalled,
  // so after a stall the wanted byte is the one saved on entry
  assign byte_in = rdy_q ? mem_data_i : byte_hold;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rdy_q <= 1'b1;
    end else begin
      rdy_q <= rdy_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rdy_q && !rdy_i) begin
      byte_hold <= mem_data_i;
    end
  end

  // mem_addr_o doubles as the program counter
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state         <= ST_ADDR;
      mem_addr_o    <= RESET_PC;
      instr_valid_o <= 1'b0;
    end else if (rdy_i) begin
      instr_valid_o <= 1'b0;
      case (state)
        ST_ADDR: begin
          mem_addr_o <= mem_addr_o + XLEN'(1);
          state      <= ST_B0;
        end
        ST_B0: begin
          mem_addr_o <= mem_addr_o + XLEN'(1);
          state      <= ST_B1;
        end
        ST_B1: begin
          mem_addr_o <= mem_addr_o + XLEN'(1);
          state      <= ST_B2;
        end
        ST_B2: begin
          // bus now moves on to the next word at pc+4
          mem_addr_o <= mem_addr_o + XLEN'(1);
          state      <= ST_B3;
        end
        ST_B3: begin
          instr_valid_o <= 1'b1;
          state         <= ST_ADDR;
        end
        default: begin
          state <= ST_ADDR;
        end
      endcase
    end
  end

  // shift right so byte 0 ends up in bits 7:0 after four steps
  always_ff @(posedge clk) begin
    if (rdy_i && state != ST_ADDR) begin
      instr_o <= {byte_in, instr_o[XLEN-1:8]};
    end
  end

endmodule

`default_nettype wire

// ==== design/rv_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
  input  wire logic                           clk,
  input  wire logic                           rst,
  input  wire logic [rv_byte_pkg::REG_AW-1:0] rs1_addr_i,
  input  wire logic [rv_byte_pkg::REG_AW-1:0] rs2_addr_i,
  input  wire logic                           we_i,
  input  wire logic [rv_byte_pkg::REG_AW-1:0] rd_i,
  input  wire logic [rv_byte_pkg::XLEN-1:0]   wd_i,
  output logic      [rv_byte_pkg::XLEN-1:0]   rs1_data_o,
  output logic      [rv_byte_pkg::XLEN-1:0]   rs2_data_o
);
  import rv_byte_pkg::*;

  // x0 has no storage, only x1..x31
  logic [XLEN-1:0] regs [1:31];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && rd_i != '0) begin
      // writes to x0 are dropped here
      regs[rd_i] <= wd_i;
    end
  end

  // reads are combinational, x0 always reads zero
  always_comb begin
    rs1_data_o = '0;
    if (rs1_addr_i != '0) begin
      rs1_data_o = regs[rs1_addr_i];
    end
  end

  always_comb begin
    rs2_data_o = '0;
    if (rs2_addr_i != '0) begin
      rs2_data_o = regs[rs2_addr_i];
    end
  end

endmodule

`default_nettype wire

// ==== dv/rv_byte_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_byte_core_tb;
  import rv_byte_pkg::*;

  localparam int CLK_PERIOD = 8;
  localparam int RESET_CYCLES = 16;
  localparam logic [31:0] RESET_PC = 32'h0000_0040;
  localparam int MEM_BYTES = 256;
  // words per test program, drain words are fetched past the end
  localparam int N_IMM = 16;
  localparam int N_REG = 13;
  localparam int N_STALL = 16;
  localparam int N_UNSUP = 7;
  localparam int DRAIN_WORDS = 2;
  localparam int N_RUNS = 5;
  localparam int N_RESETS = 6;
  localparam int TOTAL_WORDS = N_IMM + N_REG + 2 * N_STALL + N_UNSUP + N_RUNS * DRAIN_WORDS;
  // 5 cycles per word, 4x for stalls, plus resets and a margin
  localparam int WATCHDOG_NS = TOTAL_WORDS * 5 * 4 * CLK_PERIOD
                             + N_RESETS * (RESET_CYCLES + 8) * CLK_PERIOD + 1000;

  logic        clk;
  logic        rst;
  logic        rdy_i;
  logic [7:0]  mem_data_i;
  logic [31:0] mem_addr_o;
  logic        wb_valid_o;
  logic [4:0]  wb_rd_o;
  logic [31:0] wb_data_o;

  logic [7:0]  mem [0:MEM_BYTES-1];
  logic [31:0] addr_prev;
  logic [31:0] model_regs [0:31];
  logic [4:0]  exp_rd_q [$];
  logic [31:0] exp_data_q [$];
  logic [31:0] prog_q [$];
  logic [31:0] prog_pc;
  logic [31:0] rng_state;
  logic        hold_pending;
  logic [31:0] hold_addr;

  rv_byte_core #(.RESET_PC(RESET_PC)) DUT (
    .clk(clk), .rst(rst), .rdy_i(rdy_i), .mem_data_i(mem_data_i),
    .mem_addr_o(mem_addr_o), .wb_valid_o(wb_valid_o),
    .wb_rd_o(wb_rd_o), .wb_data_o(wb_data_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // byte memory, address of cycle n answered in cycle n+1
  // out-of-range addresses read as zero so fetch never wraps into the program
  always @(negedge clk) begin
    mem_data_i <= (addr_prev < MEM_BYTES) ? mem[addr_prev[7:0]] : 8'h00;
    addr_prev  <= mem_addr_o;
  end

  task automatic stop_with_failure();
    $display("Result: FAILED");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                       input string what);
    if (actual !== expected) begin
      $display("ERROR at %0t ns: %s, got %h expected %h", $time, what, actual, expected);
      stop_with_failure();
    end
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog: the run timed out after %0d ns", WATCHDOG_NS);
    stop_with_failure();
  end

  function automatic logic [31:0] rand32();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, OPC_OP_IMM};
  endfunction

  // reference model straight from the ISA rules, x0 never written
  task automatic model_exec(input logic [31:0] w);
    logic [4:0]  rd;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic        ok;
    rd  = w[11:7];
    f3  = w[14:12];
    f7  = w[31:25];
    a   = model_regs[w[19:15]];
    ok  = 1'b1;
    res = '0;
    if (w[6:0] == OPC_OP_IMM) begin
      b = {{20{w[31]}}, w[31:20]};
      case (f3)
        F3_ADD: res = a + b;
        F3_XOR: res = a ^ b;
        F3_OR:  res = a | b;
        F3_AND: res = a & b;
        default: ok = 1'b0;
      endcase
    end else if (w[6:0] == OPC_OP) begin
      b = model_regs[w[24:20]];
      if (f7 == 7'b0100000 && f3 == F3_ADD) begin
        res = a - b;
      end else if (f7 == 7'b0000000) begin
        case (f3)
          F3_ADD: res = a + b;
          F3_XOR: res = a ^ b;
          F3_OR:  res = a | b;
          F3_AND: res = a & b;
          default: ok = 1'b0;
        endcase
      end else begin
        ok = 1'b0;
      end
    end else begin
      ok = 1'b0;
    end
    if (ok) begin
      exp_rd_q.push_back(rd);
      exp_data_q.push_back(res);
      if (rd != 5'd0) model_regs[rd] = res;
    end
  endtask

  // store little-endian at the program counter and predict the result
  task automatic emit(input logic [31:0] w);
    for (int i = 0; i < 4; i++) begin
      mem[prog_pc[7:0] + i] = w[8*i +: 8];
    end
    prog_pc = prog_pc + 32'd4;
    model_exec(w);
  endtask

  function automatic logic [31:0] random_imm_word();
    logic [31:0] r;
    logic [2:0]  f3;
    r = rand32();
    case (r[1:0])
      2'd0: f3 = F3_ADD;
      2'd1: f3 = F3_XOR;
      2'd2: f3 = F3_OR;
      default: f3 = F3_AND;
    endcase
    return enc_i(r[31:20], r[14:10], f3, (r[9:5] == 5'd0) ? 5'd1 : r[9:5]);
  endfunction

  function automatic logic [31:0] random_reg_word();
    logic [31:0] r;
    logic [2:0]  f3;
    logic [6:0]  f7;
    r  = rand32();
    f7 = 7'b0000000;
    case (r[2:0] % 5)
      0: f3 = F3_ADD;
      1: begin
        f3 = F3_ADD;
        f7 = 7'b0100000;
      end
      2: f3 = F3_XOR;
      3: f3 = F3_OR;
      default: f3 = F3_AND;
    endcase
    return enc_r(f7, r[24:20], r[19:15], f3, (r[9:5] == 5'd0) ? 5'd2 : r[9:5]);
  endfunction

  // holds the core frozen with rdy_i low after reset so a program can be loaded
  task automatic apply_reset();
    rst   = 1'b1;
    rdy_i = 1'b0;
    for (int i = 0; i < MEM_BYTES; i++) mem[i] = 8'h00;
    for (int i = 0; i < 32; i++) model_regs[i] = '0;
    exp_rd_q.delete();
    exp_data_q.delete();
    prog_pc = RESET_PC;
    repeat (RESET_CYCLES) @(negedge clk);
    rst = 1'b0;
  endtask

  // runs until fetch is two words past the program, random stretches of rdy_i low
  task automatic run_program(input int n_words, input bit stalls);
    int          cycles;
    int          stall_left;
    logic [31:0] end_addr;
    end_addr   = RESET_PC + 32'(4 * n_words + 4 * DRAIN_WORDS);
    cycles     = 0;
    stall_left = 0;
    while (mem_addr_o < end_addr) begin
      @(negedge clk);
      if (stalls && stall_left > 0) begin
        rdy_i = 1'b0;
        stall_left--;
      end else if (stalls && rand32() % 4 == 0) begin
        rdy_i      = 1'b0;
        stall_left = rand32() % 3;
      end else begin
        rdy_i = 1'b1;
      end
      cycles++;
      if (cycles > (n_words + DRAIN_WORDS) * 5 * 4) begin
        $display("fetch did not get past a %0d word program in %0d cycles", n_words, cycles);
        stop_with_failure();
      end
    end
    @(negedge clk);
    rdy_i = 1'b0;
    check(exp_rd_q.size(), 0, "writebacks still missing after the run");
  endtask

  // writeback counts once, on the edge where rdy_i lets it through
  always @(posedge clk) begin
    if (rst) begin
      hold_pending = 1'b0;
    end else begin
      if (hold_pending) check(mem_addr_o, hold_addr, "mem_addr_o moved while rdy_i low");
      hold_pending = !rdy_i;
      hold_addr    = mem_addr_o;
      if (wb_valid_o && rdy_i) begin
        if (exp_rd_q.size() == 0) begin
          $display("unexpected writeback to x%0d with %h at %0t ns", wb_rd_o, wb_data_o, $time);
          stop_with_failure();
        end else begin
          check(wb_rd_o, exp_rd_q.pop_front(), "writeback register index");
          check(wb_data_o, exp_data_q.pop_front(), "writeback data");
        end
      end
    end
  end

  task automatic test_reset_state();
    apply_reset();
    check(mem_addr_o, RESET_PC, "mem_addr_o after reset");
    check(wb_valid_o, 1'b0, "wb_valid_o after reset");
    repeat (3) @(negedge clk);
    check(wb_valid_o, 1'b0, "wb_valid_o while frozen after reset");
  endtask

  task automatic test_imm_ops();
    logic [31:0] w;
    apply_reset();
    for (int i = 0; i < N_IMM; i++) begin
      w = random_imm_word();
      // every other immediate is negative
      if (i % 2 == 1) w[31] = 1'b1;
      emit(w);
    end
    run_program(N_IMM, 1'b0);
  endtask

  task automatic test_reg_ops();
    apply_reset();
    emit(enc_i(12'd100, 5'd0, F3_ADD, 5'd1));
    emit(enc_i(12'd250, 5'd0, F3_ADD, 5'd2));
    emit(enc_r(7'b0000000, 5'd2, 5'd1, F3_ADD, 5'd3));
    // 100 - 250 wraps below zero
    emit(enc_r(7'b0100000, 5'd2, 5'd1, F3_ADD, 5'd4));
    emit(enc_i(12'hfff, 5'd0, F3_XOR, 5'd5));
    emit(enc_i(12'h555, 5'd0, F3_ADD, 5'd6));
    emit(enc_r(7'b0000000, 5'd6, 5'd5, F3_XOR, 5'd7));
    emit(enc_r(7'b0000000, 5'd6, 5'd4, F3_OR, 5'd8));
    emit(enc_r(7'b0000000, 5'd4, 5'd5, F3_AND, 5'd9));
    emit(enc_r(7'b0100000, 5'd1, 5'd0, F3_ADD, 5'd10));
    // write x0, then read it back as zero
    emit(enc_r(7'b0000000, 5'd2, 5'd1, F3_ADD, 5'd0));
    emit(enc_r(7'b0000000, 5'd1, 5'd0, F3_ADD, 5'd11));
    emit(enc_r(7'b0100000, 5'd3, 5'd3, F3_ADD, 5'd12));
    run_program(N_REG, 1'b0);
  endtask

  task automatic test_stalls();
    logic [31:0] r;
    apply_reset();
    prog_q.delete();
    for (int i = 0; i < N_STALL; i++) begin
      r = rand32();
      prog_q.push_back(r[0] ? random_reg_word() : random_imm_word());
    end
    foreach (prog_q[i]) emit(prog_q[i]);
    run_program(N_STALL, 1'b0);
    // same program again, the model predicts the same sequence
    apply_reset();
    foreach (prog_q[i]) emit(prog_q[i]);
    run_program(N_STALL, 1'b1);
  endtask

  task automatic test_unsupported();
    apply_reset();
    emit(enc_i(12'd7, 5'd0, F3_ADD, 5'd1));
    // slli x2, x1, 3
    emit(enc_i(12'd3, 5'd1, 3'b001, 5'd2));
    emit(enc_i(12'd5, 5'd1, F3_ADD, 5'd3));
    // sw x1, 8(x0)
    emit({7'd0, 5'd1, 5'd0, 3'b010, 5'd8, 7'b0100011});
    emit(enc_i(12'hffe, 5'd3, F3_XOR, 5'd4));
    emit(enc_r(7'b0000000, 5'd3, 5'd1, F3_ADD, 5'd5));
    // x2 was never written
    emit(enc_r(7'b0000000, 5'd1, 5'd2, F3_ADD, 5'd6));
    run_program(N_UNSUP, 1'b0);
  endtask

  initial begin
    rst          = 1'b1;
    rdy_i        = 1'b0;
    mem_data_i   = 8'h00;
    addr_prev    = RESET_PC;
    hold_pending = 1'b0;
    hold_addr    = '0;
    prog_pc      = RESET_PC;
    rng_state    = 32'd39305;
    test_reset_state();
    test_imm_ops();
    test_reg_ops();
    test_stalls();
    test_unsupported();
    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== rv_byte_core.f ====
design/rv_byte_pkg.sv
design/rv_fetch.sv
design/rv_regfile.sv
design/rv_decode.sv
design/rv_execute.sv
design/rv_byte_core.sv
dv/rv_byte_core_tb.sv
